// File: list.f
+incdir+logic
logic/tcb_pkg.sv
logic/tcb_requester.sv
logic/tcb_request_fifo.sv
logic/tcb_memory.sv
logic/tcb_subsystem.sv
testbench/tcb_clock_gen.sv
testbench/tcb_subsystem_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tcb_subsystem_tb
FILELIST  = list.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "RESULT: PASS" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: testbench/tcb_subsystem_tb.sv
/*
  TCB subsystem testbench
  directed and random commands against a byte-array reference model,
  responses checked by concurrent assertions against an expected queue
*/
`include "tcb_config.svh"

module tcb_subsystem_tb
  import tcb_pkg::*;
();

  localparam int     LAT     = 2 + `TCB_RD_DLY;
  localparam int     N_FILL  = `TCB_MEM_SIZ / `TCB_BEN;
  localparam int     N_BURST = 3 * `TCB_FIFO_DEPTH;
  localparam int     N_RAND  = 400;
  localparam int     N_CMD   = N_FILL + 4 + 10 + N_BURST + 8 + N_RAND;
  localparam longint WDOG_T  = longint'(N_CMD) * (2 + `TCB_RD_DLY + `TCB_FIFO_DEPTH) * 10
                               + 2000;
  localparam int     EXP_W   = 10;
  // longest wait for outstanding responses after the last command
  localparam int     DRAIN_MAX = 4 * (LAT + `TCB_FIFO_DEPTH);

  logic     tcb;
  logic     rst_n;
  tcb_cmd_t cmd;
  logic     cmd_vld;
  logic     cmd_rdy;
  tcb_rsp_t rsp;
  logic     rsp_vld;

  // reference memory and expected response ring
  logic [7:0]       ref_mem [0:`TCB_MEM_SIZ-1];
  tcb_rsp_t         exp_rsp [0:2**EXP_W-1];
  int               exp_cyc [0:2**EXP_W-1];
  logic             exp_lat [0:2**EXP_W-1];
  logic [EXP_W-1:0] exp_wr = '0;
  logic [EXP_W-1:0] exp_rd = '0;
  tcb_rsp_t         exp_head;
  int               exp_cyc_head;
  logic             exp_lat_head;

  int          cyc        = 0;
  int          acc_cnt    = 0;
  int          rsp_cnt    = 0;
  int          err_cnt    = 0;
  int          test_err0  = 0;
  int          test_num   = 0;
  int          test_pass  = 0;
  int          test_fail  = 0;
  logic        lat_check  = 1'b0;
  logic        stall_seen = 1'b0;
  logic [31:0] rng        = 32'h6281;

  tcb_clock_gen clock_gen_i (
    .tcb   (tcb),
    .rst_n (rst_n)
  );

  tcb_subsystem dut_i (
    .tcb     (tcb),
    .rst_n   (rst_n),
    .cmd     (cmd),
    .cmd_vld (cmd_vld),
    .cmd_rdy (cmd_rdy),
    .rsp     (rsp),
    .rsp_vld (rsp_vld)
  );

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  // odd multiplier keeps every address bit in the pattern
  function automatic logic [7:0] fill_byte(input int unsigned a);
    return 8'(a * 29 + 7);
  endfunction

  function automatic tcb_cmd_t make_cmd(input tcb_op_t op, input int unsigned adr,
                                        input int unsigned siz, input logic [31:0] wdt);
    tcb_cmd_t c;
    c.op  = op;
    c.adr = `TCB_ADR_W'(adr);
    c.siz = 2'(siz);
    c.wdt = wdt;
    return c;
  endfunction

  // byte b sits at address (adr+b) mod size on lane (adr+b) mod 4
  function automatic tcb_rsp_t model_access(input tcb_cmd_t c);
    tcb_rsp_t    r;
    int unsigned a;
    int unsigned lane;
    r.op  = c.op;
    r.rdt = '0;
    for (int unsigned b = 0; b < (32'd1 << c.siz); b++) begin
      a    = (32'(c.adr) + b) % `TCB_MEM_SIZ;
      lane = (32'(c.adr) + b) % `TCB_BEN;
      if (c.op == TCB_OP_WRITE) begin
        ref_mem[a] = c.wdt[b];
      end else begin
        r.rdt[lane] = ref_mem[a];
      end
    end
    return r;
  endfunction

  // runs between falling edges
  // cmd stays valid until taken
  task automatic send_cmd(input tcb_cmd_t c);
    cmd     = c;
    cmd_vld = 1'b1;
    while (!cmd_rdy) begin
      stall_seen = 1'b1;
      @(negedge tcb);
    end
    @(negedge tcb);
    cmd_vld = 1'b0;
  endtask

  task automatic idle_cycles(input int unsigned n);
    repeat (n) @(negedge tcb);
  endtask

  task automatic check_counts();
    count_match: assert (rsp_cnt == acc_cnt) else begin
      $display("[FAIL] %0t responses %0d, accepted commands %0d", $time, rsp_cnt, acc_cnt);
      err_cnt++;
    end
  endtask

  // bounded wait for the expected queue to empty
  task automatic wait_drain();
    int unsigned n;
    n = 0;
    while ((exp_rd != exp_wr) && (n < DRAIN_MAX)) begin
      @(negedge tcb);
      n++;
    end
    @(negedge tcb);
    check_counts();
  endtask

  task automatic end_test(input string name);
    test_num++;
    if (err_cnt == test_err0) begin
      test_pass++;
      $display("test %0d %s passed at %0t", test_num, name, $time);
    end else begin
      test_fail++;
      $display("test %0d %s failed with %0d errors", test_num, name, err_cnt - test_err0);
    end
    test_err0 = err_cnt;
  endtask

  ////////////////////////////////////////
  // monitor and checks
  ////////////////////////////////////////

  assign exp_head     = exp_rsp[exp_rd];
  assign exp_cyc_head = exp_cyc[exp_rd];
  assign exp_lat_head = exp_lat[exp_rd];

  // model follows command order at acceptance
  always @(posedge tcb) begin
    if (rst_n) begin
      cyc <= cyc + 1;
      if (cmd_vld && cmd_rdy) begin
        exp_rsp[exp_wr] <= model_access(cmd);
        exp_cyc[exp_wr] <= cyc;
        exp_lat[exp_wr] <= lat_check;
        exp_wr          <= exp_wr + 1'b1;
        acc_cnt         <= acc_cnt + 1;
      end
      if (rsp_vld) begin
        exp_rd  <= exp_rd + 1'b1;
        rsp_cnt <= rsp_cnt + 1;
      end
    end
  end

  reset_vals: assert property (@(posedge tcb) (!rst_n || $rose(rst_n)) |->
    (cmd_rdy && !rsp_vld)) else begin
    $display("error at %0t: cmd_rdy or rsp_vld wrong in or just after reset", $time);
    err_cnt++;
  end

  rsp_expected: assert property (@(posedge tcb) disable iff (!rst_n)
    rsp_vld |-> (exp_rd != exp_wr)) else begin
    $display("error at %0t: response arrived with no command outstanding", $time);
    err_cnt++;
  end

  // op sits in the top bit above the lanes
  rsp_match: assert property (@(posedge tcb) disable iff (!rst_n)
    (rsp_vld && (exp_rd != exp_wr)) |-> (rsp === exp_head)) else begin
    $display("[FAIL] %0t response got %h expected %h", $time, $sampled(rsp),
             $sampled(exp_head));
    err_cnt++;
  end

  rsp_latency: assert property (@(posedge tcb) disable iff (!rst_n)
    (rsp_vld && exp_lat_head) |-> ((cyc - exp_cyc_head) == LAT)) else begin
    $display("[FAIL] %0t latency %0d cycles, expected %0d", $time,
             $sampled(cyc) - $sampled(exp_cyc_head), LAT);
    err_cnt++;
  end

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////

  // whole memory known before any read
  task automatic fill_memory();
    logic [31:0] w;
    for (int unsigned a = 0; a < `TCB_MEM_SIZ; a += `TCB_BEN) begin
      for (int unsigned b = 0; b < `TCB_BEN; b++) begin
        w[8*b +: 8] = fill_byte(a + b);
      end
      send_cmd(make_cmd(TCB_OP_WRITE, a, 2, w));
    end
    wait_drain();
  endtask

  task automatic word_access();
    lat_check = 1'b1;
    send_cmd(make_cmd(TCB_OP_WRITE, 'h040, 2, 32'hdeadbeef));
    wait_drain();
    send_cmd(make_cmd(TCB_OP_READ, 'h040, 2, 32'hffffffff));
    wait_drain();
    // back to back pair
    send_cmd(make_cmd(TCB_OP_WRITE, 'h0a8, 2, 32'h0badf00d));
    send_cmd(make_cmd(TCB_OP_READ, 'h0a8, 2, 32'h0));
    wait_drain();
  endtask

  // upper wdt bytes must be dropped
  task automatic subword_access();
    send_cmd(make_cmd(TCB_OP_WRITE, 'h051, 0, 32'h555555c3));
    send_cmd(make_cmd(TCB_OP_WRITE, 'h053, 1, 32'h6666a1b2));
    send_cmd(make_cmd(TCB_OP_WRITE, 'h061, 1, 32'h77777e5d));
    send_cmd(make_cmd(TCB_OP_WRITE, 'h067, 0, 32'h8888883c));
    send_cmd(make_cmd(TCB_OP_READ, 'h050, 2, 32'h0));
    send_cmd(make_cmd(TCB_OP_READ, 'h054, 2, 32'h0));
    send_cmd(make_cmd(TCB_OP_READ, 'h060, 2, 32'h0));
    send_cmd(make_cmd(TCB_OP_READ, 'h064, 2, 32'h0));
    // narrow reads leave the other lanes zero
    send_cmd(make_cmd(TCB_OP_READ, 'h052, 0, 32'h0));
    send_cmd(make_cmd(TCB_OP_READ, 'h053, 1, 32'h0));
    wait_drain();
    lat_check = 1'b0;
  endtask

  task automatic credit_burst();
    stall_seen = 1'b0;
    for (int i = 0; i < N_BURST; i++) begin
      rng = xorshift32(rng);
      send_cmd(make_cmd((i % 2) ? TCB_OP_READ : TCB_OP_WRITE, 'h080 + 4 * (i / 2), 2, rng));
    end
    wait_drain();
    burst_stall: assert (stall_seen) else begin
      $display("error at %0t: cmd_rdy never dropped during the burst", $time);
      err_cnt++;
    end
  endtask

  // bytes past the top of memory land at address zero
  task automatic address_wrap();
    send_cmd(make_cmd(TCB_OP_WRITE, 'h0fe, 2, 32'h11223344));
    send_cmd(make_cmd(TCB_OP_READ, 'h0fc, 2, 32'h0));
    send_cmd(make_cmd(TCB_OP_READ, 'h000, 2, 32'h0));
    send_cmd(make_cmd(TCB_OP_READ, 'h0fe, 2, 32'h0));
    send_cmd(make_cmd(TCB_OP_WRITE, 'h3ff, 1, 32'h0000a55a));
    send_cmd(make_cmd(TCB_OP_READ, 'h3fc, 2, 32'h0));
    send_cmd(make_cmd(TCB_OP_READ, 'h100, 2, 32'h0));
    send_cmd(make_cmd(TCB_OP_READ, 'h3ff, 1, 32'h0));
    wait_drain();
  endtask

  task automatic random_mix();
    logic [31:0] r0;
    logic [31:0] r1;
    tcb_op_t     op;
    for (int i = 0; i < N_RAND; i++) begin
      rng = xorshift32(rng);
      r0  = rng;
      rng = xorshift32(rng);
      r1  = rng;
      op  = r0[0] ? TCB_OP_WRITE : TCB_OP_READ;
      send_cmd(make_cmd(op, 32'(r0[10:1]), 32'(r0[20:12]) % 3, r1));
      idle_cycles(32'(r0[31:30]));
    end
    wait_drain();
  endtask

  initial begin
    cmd     = '0;
    cmd_vld = 1'b0;
    wait (rst_n === 1'b1);
    @(negedge tcb);
    // quiet window after reset release
    idle_cycles(4);
    end_test("reset");
    fill_memory();
    end_test("mem_fill");
    word_access();
    end_test("word");
    subword_access();
    end_test("subword");
    credit_burst();
    end_test("burst");
    address_wrap();
    end_test("wrap");
    random_mix();
    end_test("random");
    $display("tests %0d, passed %0d, failed %0d, errors %0d, commands %0d, responses %0d",
             test_num, test_pass, test_fail, err_cnt, acc_cnt, rsp_cnt);
    if ((test_fail == 0) && (err_cnt == 0)) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(WDOG_T);
    $display("timeout: run did not finish within %0d time units", WDOG_T);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

// File: testbench/tcb_clock_gen.sv
/*
  TCB clock and reset source
  clock period 10, reset held low for the first 8 cycles
*/
module tcb_clock_gen (
  output logic tcb,
  output logic rst_n
);

  initial begin
    tcb = 1'b0;
    forever #5 tcb = ~tcb;
  end

  // release on a falling edge, clear of the active edge
  initial begin
    rst_n = 1'b0;
    repeat (8) @(posedge tcb);
    @(negedge tcb);
    rst_n = 1'b1;
  end

endmodule

// File: logic/tcb_subsystem.sv
/*
  TCB subsystem top
  requester, credit-based request FIFO and memory in a chain
*/
`include "tcb_config.svh"

module tcb_subsystem
  import tcb_pkg::*;
(
  input  logic     tcb,
  input  logic     rst_n,
  // command port
  input  tcb_cmd_t cmd,
  input  logic     cmd_vld,
  output logic     cmd_rdy,
  // response port
  output tcb_rsp_t rsp,
  output logic     rsp_vld
);

  // requester to FIFO
  tcb_req_t req;
  logic     req_vld;
  logic     crd_ret;
  // FIFO to memory
  tcb_req_t mem_req;
  logic     mem_trn;

  tcb_requester requester_i (
    .tcb     (tcb),
    .rst_n   (rst_n),
    .cmd     (cmd),
    .cmd_vld (cmd_vld),
    .cmd_rdy (cmd_rdy),
    .req     (req),
    .req_vld (req_vld),
    .crd_ret (crd_ret)
  );

  tcb_request_fifo fifo_i (
    .tcb     (tcb),
    .rst_n   (rst_n),
    .req     (req),
    .req_vld (req_vld),
    .mem_req (mem_req),
    .mem_trn (mem_trn),
    .crd_ret (crd_ret)
  );

  tcb_memory memory_i (
    .tcb     (tcb),
    .rst_n   (rst_n),
    .mem_req (mem_req),
    .mem_trn (mem_trn),
    .rsp     (rsp),
    .rsp_vld (rsp_vld)
  );

endmodule

// File: logic/tcb_memory.sv
/*
  TCB memory
  byte array in byte-enable mode, access in the transfer cycle,
  read data and responses delayed by a fixed pipeline
*/
`include "tcb_config.svh"

module tcb_memory
  import tcb_pkg::*;
(
  input  logic     tcb,
  input  logic     rst_n,
  // request from FIFO
  input  tcb_req_t mem_req,
  input  logic     mem_trn,
  // response, no back-pressure
  output tcb_rsp_t rsp,
  output logic     rsp_vld
);

  localparam int unsigned DLY = `TCB_RD_DLY;

  logic [8-1:0] mem [0:`TCB_MEM_SIZ-1];

  // per byte offset, memory address and data lane
  int unsigned  mem_idx  [`TCB_BEN];
  int unsigned  lane_idx [`TCB_BEN];

  tcb_dat_t     rdt_0;
  tcb_rsp_t     rsp_0;

  // delay pipeline, stage DLY drives the response
  logic [DLY:1] dly_vld;
  tcb_rsp_t     dly_rsp [1:DLY];

  ////////////////////////////////////////
  // address to lane mapping
  ////////////////////////////////////////

  for (genvar b = 0; b < `TCB_BEN; b++) begin : g_byte
    // address wraps at memory size
    assign mem_idx[b]  = (32'(mem_req.adr) + b) % `TCB_MEM_SIZ;
    assign lane_idx[b] = (32'(mem_req.adr) + b) % `TCB_BEN;
  end

  ////////////////////////////////////////
  // access
  ////////////////////////////////////////

  // write enabled lanes at the end of the transfer cycle
  always_ff @(posedge tcb) begin
    if (mem_trn && (mem_req.op == TCB_OP_WRITE)) begin
      for (int unsigned b = 0; b < `TCB_BEN; b++) begin
        if (mem_req.ben[lane_idx[b]]) begin
          mem[mem_idx[b]] <= mem_req.wdt[lane_idx[b]];
        end
      end
    end
  end

  // read enabled lanes, others zero
  // writes also carry zero data
  always_comb begin
    rdt_0 = '0;
    if (mem_trn && (mem_req.op == TCB_OP_READ)) begin
      for (int unsigned b = 0; b < `TCB_BEN; b++) begin
        if (mem_req.ben[lane_idx[b]]) begin
          rdt_0[lane_idx[b]] = mem[mem_idx[b]];
        end
      end
    end
  end

  assign rsp_0 = '{op: mem_req.op, rdt: rdt_0};

  ////////////////////////////////////////
  // delay pipeline
  ////////////////////////////////////////

  // valid per stage
  always_ff @(posedge tcb or negedge rst_n) begin
    if (!rst_n) begin
      dly_vld <= '0;
    end else begin
      dly_vld[1] <= mem_trn;
      for (int unsigned d = 2; d <= DLY; d++) begin
        dly_vld[d] <= dly_vld[d-1];
      end
    end
  end

  // opcode and data follow
  always_ff @(posedge tcb) begin
    dly_rsp[1] <= rsp_0;
    for (int unsigned d = 2; d <= DLY; d++) begin
      dly_rsp[d] <= dly_rsp[d-1];
    end
  end

  assign rsp     = dly_rsp[DLY];
  assign rsp_vld = dly_vld[DLY];

  // FIFO never hands over an unwritten entry
  req_known: assert property (@(posedge tcb) disable iff (!rst_n)
    mem_trn |-> !$isunknown(mem_req));

endmodule

// File: logic/tcb_request_fifo.sv
/*
  TCB request FIFO
  circular queue between requester and memory, pops one entry per cycle
  and returns a credit with every pop
*/
`include "tcb_config.svh"

module tcb_request_fifo
  import tcb_pkg::*;
(
  input  logic     tcb,
  input  logic     rst_n,
  // from requester
  input  tcb_req_t req,
  input  logic     req_vld,
  // to memory
  output tcb_req_t mem_req,
  output logic     mem_trn,
  // credit back to requester
  output logic     crd_ret
);

  localparam int unsigned DEPTH = `TCB_FIFO_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  tcb_req_t         fifo_mem [0:DEPTH-1];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] cnt;
  logic             push;
  logic             pop;

  // pointer step with wrap at DEPTH
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  ////////////////////////////////////////
  // queue control
  ////////////////////////////////////////

  assign push = req_vld;
  // memory is always ready, drain whenever something is queued
  assign pop  = (cnt != '0);

  assign mem_trn = pop;
  assign crd_ret = pop;
  assign mem_req = fifo_mem[rd_ptr];

  // storage
  always_ff @(posedge tcb) begin
    if (push) begin
      fifo_mem[wr_ptr] <= req;
    end
  end

  always_ff @(posedge tcb or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({push, pop})
        2'b10:   cnt <= cnt + 1'b1;
        2'b01:   cnt <= cnt - 1'b1;
        default: cnt <= cnt;
      endcase
    end
  end

  // credits keep the requester from writing a full queue
  no_overflow: assert property (@(posedge tcb) disable iff (!rst_n)
    req_vld |-> (cnt < CNT_W'(DEPTH)));

endmodule

// File: logic/tcb_requester.sv
/*
  TCB requester
  takes one command at a time, converts size into rotated byte enables,
  moves write data onto lanes and sends it as a request once a credit is held
*/
`include "tcb_config.svh"

module tcb_requester
  import tcb_pkg::*;
(
  input  logic     tcb,
  input  logic     rst_n,
  // command port
  input  tcb_cmd_t cmd,
  input  logic     cmd_vld,
  output logic     cmd_rdy,
  // request port towards FIFO
  output tcb_req_t req,
  output logic     req_vld,
  input  logic     crd_ret
);

  localparam int unsigned CRD_W = $clog2(`TCB_FIFO_DEPTH + 1);

  tcb_req_state_t   state;
  tcb_req_state_t   state_nxt;
  logic [CRD_W-1:0] crd_cnt;
  logic             cmd_trn;
  tcb_req_t         req_nxt;

  ////////////////////////////////////////
  // handshake
  ////////////////////////////////////////

  // ready only with no command held
  assign cmd_rdy = (state == IDLE);
  assign cmd_trn = cmd_vld & cmd_rdy;
  // ISSUE is only entered with a credit in hand
  assign req_vld = (state == ISSUE);

  ////////////////////////////////////////
  // lane mapping
  ////////////////////////////////////////

  // byte b of the command goes to lane (adr+b) mod BEN
  always_comb begin
    int unsigned lane;
    req_nxt.op  = cmd.op;
    req_nxt.adr = cmd.adr;
    req_nxt.ben = '0;
    req_nxt.wdt = '0;
    for (int unsigned b = 0; b < `TCB_BEN; b++) begin
      lane = (cmd.adr + b) % `TCB_BEN;
      // only the first 2**siz bytes
      if (b < (32'd1 << cmd.siz)) begin
        req_nxt.ben[lane] = 1'b1;
        req_nxt.wdt[lane] = cmd.wdt[b];
      end
    end
  end

  // held command, payload only
  always_ff @(posedge tcb) begin
    if (cmd_trn) begin
      req <= req_nxt;
    end
  end

  ////////////////////////////////////////
  // FSM
  ////////////////////////////////////////

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (cmd_trn) begin
          if (crd_cnt != '0) begin
            state_nxt = ISSUE;
          end else begin
            state_nxt = STALL;
          end
        end
      end
      // request leaves this cycle
      ISSUE: state_nxt = IDLE;
      // wait for a returned credit
      STALL: begin
        if (crd_cnt != '0) begin
          state_nxt = ISSUE;
        end
      end
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge tcb or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // credit counter, spend and return may coincide
  always_ff @(posedge tcb or negedge rst_n) begin
    if (!rst_n) begin
      crd_cnt <= CRD_W'(`TCB_FIFO_DEPTH);
    end else begin
      case ({req_vld, crd_ret})
        2'b10:   crd_cnt <= crd_cnt - 1'b1;
        2'b01:   crd_cnt <= crd_cnt + 1'b1;
        default: crd_cnt <= crd_cnt;
      endcase
    end
  end

  // FIFO returns no more credits than were spent
  crd_range: assert property (@(posedge tcb) disable iff (!rst_n)
    (crd_cnt <= CRD_W'(`TCB_FIFO_DEPTH)) && !(req_vld && (crd_cnt == '0)));

endmodule

// File: logic/tcb_pkg.sv
/*
  TCB package
  opcode and requester state encodings, command, request and response structs
*/
`include "tcb_config.svh"

package tcb_pkg;

  ////////////////////////////////////////
  // field types
  ////////////////////////////////////////

  typedef logic [`TCB_ADR_W-1:0] tcb_adr_t;
  // data as bytes, index is the lane
  typedef logic [`TCB_BEN-1:0][8-1:0] tcb_dat_t;
  typedef logic [`TCB_BEN-1:0] tcb_ben_t;

  // transfer opcode
  typedef enum logic {
    TCB_OP_READ  = 1'b0,
    TCB_OP_WRITE = 1'b1
  } tcb_op_t;

  // requester FSM
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    ISSUE = 2'd1,
    STALL = 2'd2
  } tcb_req_state_t;

  ////////////////////////////////////////
  // transfer structs
  ////////////////////////////////////////

  // command, wdt byte b belongs to address adr+b
  typedef struct packed {
    tcb_op_t    op;
    tcb_adr_t   adr;
    logic [1:0] siz;  // log2 of bytes
    tcb_dat_t   wdt;
  } tcb_cmd_t;

  // request, wdt already placed on byte lanes
  typedef struct packed {
    tcb_op_t  op;
    tcb_adr_t adr;
    tcb_ben_t ben;
    tcb_dat_t wdt;
  } tcb_req_t;

  // response, rdt on byte lanes
  typedef struct packed {
    tcb_op_t  op;
    tcb_dat_t rdt;
  } tcb_rsp_t;

endpackage

// File: logic/tcb_config.svh
/*
  TCB subsystem configuration
  bus widths, memory size, request queue depth and read latency
*/
`ifndef TCB_CONFIG_SVH
`define TCB_CONFIG_SVH

// address width in bits
`define TCB_ADR_W 10
// data bytes per transfer
`define TCB_BEN 4
// memory size in bytes, addresses wrap at this size
`define TCB_MEM_SIZ 256
// request FIFO entries, also the initial credit count
`define TCB_FIFO_DEPTH 4
// read delay pipeline stages
`define TCB_RD_DLY 2

`endif
